// ==== list.f ====
logic/gbc_pkg.sv
logic/settings_if.sv
logic/cycle_timer.sv
logic/cfg_regs.sv
logic/ff_fsm.sv
logic/av_output.sv
logic/gbc_av_top.sv
verification/tb_gbc_av.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f list.f \
    --top-module tb_gbc_av -o sim_gbc_av
./obj_dir/sim_gbc_av | tee sim.log
if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/tb_gbc_av.sv ====
`timescale 1ns/100ps

module tb_gbc_av;

    import gbc_pkg::*;

    // all scenarios together run about 3k cycles
    localparam int MAX_CYCLES = 20000;

    logic         clk_sys;
    logic         arst_n;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    logic         ff_button;
    rgb_t         src_rgb;
    logic         src_hs, src_vs, src_hblank, src_vblank;
    sample_t      audio_l_in, audio_r_in;
    rgb_t         video_rgb;
    logic         video_de, video_hs, video_vs;
    sample_t      audio_l, audio_r;
    logic         core_reset;
    logic         ff_active;

    // reference model state, advanced on every rising edge
    int          errors;
    int          cycles;
    int          pix;
    int          hs_left;
    int          rst_left;
    int          held;
    string       test_name;
    logic        model_live;
    logic        m_bw, m_snd, m_ff, ff_expect;
    logic        hs_prev, vs_prev, snd_pre, ff_pre;
    logic        exp_de, exp_hs, exp_vs;
    rgb_t        exp_rgb;
    sample_t     exp_l, exp_r;

    gbc_av_top i_gbc_av_top (.*);

    always #2 clk_sys = ~clk_sys;

    ////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////

    // weighted luma from truncating divides, kept to 8 bits
    function automatic logic [7:0] ref_lum(input rgb_t px);
        int sum;
        sum = px[23:16] / 4 + px[23:16] / 32 + px[15:8] / 2 + px[15:8] / 16
            + px[7:0] / 16 + px[7:0] / 32;
        return sum[7:0];
    endfunction

    function automatic rgb_t ref_video(input rgb_t px, input logic blank, input logic gray);
        rgb_t       shown;
        logic [7:0] y;
        shown = blank ? rgb_t'(0) : px;
        y     = ref_lum(shown);
        return gray ? {y, y, y} : shown;
    endfunction

    function automatic sample_t ref_audio(input sample_t s, input logic ff_on, input logic snd_on);
        return (ff_on && !snd_on) ? sample_t'(0) : s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // model update and comparison
    ////////////////////////////////////////

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: scenarios still running after %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end else if (!arst_n) begin
            model_live = 1'b0;
            {m_bw, m_snd, m_ff, hs_prev, vs_prev} = '0;
            hs_left  = 0;
            rst_left = 0;
        end else begin
            model_live = 1'b1;
            // audio mute uses the settings from before this edge
            snd_pre = m_snd;
            ff_pre  = m_ff;
            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_FF_SND_EN: m_snd = bridge_wr_data[0];
                    ADDR_BW_EN:     m_bw = bridge_wr_data[0];
                    default: ;
                endcase
            end
            if (bridge_wr && bridge_addr == ADDR_RESET) begin
                rst_left = RESET_HOLD_CYCLES;
            end else if (rst_left != 0) begin
                rst_left--;
            end
            m_ff    = ff_expect;
            exp_de  = !(src_hblank || src_vblank);
            exp_rgb = ref_video(src_rgb, !exp_de, m_bw);
            exp_vs  = src_vs && !vs_prev;
            exp_hs  = 1'b0;
            if (src_hs && !hs_prev) begin
                hs_left = HS_DELAY_CYCLES;
            end else if (hs_left != 0) begin
                hs_left--;
                exp_hs = (hs_left == 0);
            end
            hs_prev = src_hs;
            vs_prev = src_vs;
            exp_l   = ref_audio(audio_l_in, ff_pre, snd_pre);
            exp_r   = ref_audio(audio_r_in, ff_pre, snd_pre);
        end
    end

    // outputs are all registered, so they are settled at the falling edge
    always @(negedge clk_sys) begin
        if (model_live) begin
            check_value({test_name, " video_rgb"}, 32'(exp_rgb), 32'(video_rgb));
            check_value({test_name, " video_de"}, 32'(exp_de), 32'(video_de));
            check_value({test_name, " video_vs"}, 32'(exp_vs), 32'(video_vs));
            check_value({test_name, " video_hs"}, 32'(exp_hs), 32'(video_hs));
            check_value({test_name, " audio_l"}, 32'(exp_l), 32'(audio_l));
            check_value({test_name, " audio_r"}, 32'(exp_r), 32'(audio_r));
            check_value({test_name, " ff_active"}, 32'(m_ff), 32'(ff_active));
            check_value({test_name, " core_reset"}, 32'(rst_left != 0), 32'(core_reset));
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // hsync every 20 pixels, vsync every 160
    task automatic drive_video(input int n);
        repeat (n) begin
            @(negedge clk_sys);
            pix++;
            src_rgb    = rgb_t'($urandom);
            src_hblank = ($urandom % 4) == 0;
            src_vblank = ($urandom % 8) == 0;
            src_hs     = (pix % 20) < 3;
            src_vs     = (pix % 160) < 4;
            audio_l_in = sample_t'($urandom);
            audio_r_in = sample_t'($urandom);
        end
    endtask

    task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        @(negedge clk_sys);
        bridge_wr      = 1'b0;
    endtask

    task automatic push_button(input int hold, input logic active_while, input logic active_after);
        ff_button = 1'b1;
        ff_expect = active_while;
        drive_video(hold);
        ff_button = 1'b0;
        ff_expect = active_after;
        drive_video(30);
    endtask

    // length of the core reset seen from here, bounded
    task automatic measure_reset(output int length);
        length = 0;
        while (core_reset && length < 1000) begin
            length++;
            @(negedge clk_sys);
        end
    endtask

    initial begin
        void'($urandom(7));
        clk_sys        = 1'b0;
        arst_n         = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        ff_button      = 1'b0;
        src_rgb        = '0;
        {src_hs, src_vs} = 2'b00;
        {src_hblank, src_vblank} = 2'b11;
        audio_l_in     = '0;
        audio_r_in     = '0;
        ff_expect      = 1'b0;
        test_name      = "reset_values";
        repeat (5) @(negedge clk_sys);
        arst_n = 1'b1;
        check_value("reset_values core_reset", 0, 32'(core_reset));
        check_value("reset_values ff_active", 0, 32'(ff_active));
        check_value("reset_values video_de", 0, 32'(video_de));
        check_value("reset_values video_hs", 0, 32'(video_hs));
        check_value("reset_values video_vs", 0, 32'(video_vs));

        test_name = "video";
        drive_video(300);
        bus_write(ADDR_BW_EN, 32'h1);
        test_name = "gray";
        drive_video(300);
        bus_write(ADDR_BW_EN, 32'h0);
        test_name = "sync";
        drive_video(400);

        test_name = "reset_hold";
        bus_write(ADDR_RESET, 32'h1);
        measure_reset(held);
        check_value("reset_hold length", 32'(RESET_HOLD_CYCLES), 32'(held));
        bus_write(ADDR_RESET, 32'h1);
        repeat (99) @(negedge clk_sys);
        // without the restart only 156 cycles would remain
        bus_write(ADDR_RESET, 32'h1);
        measure_reset(held);
        check_value("reset_rewrite length", 32'(RESET_HOLD_CYCLES), 32'(held));

        test_name = "ff_tap";
        bus_write(ADDR_FF_EN, 32'h1);
        push_button(50, 1'b1, 1'b1);
        test_name = "ff_unlatch";
        push_button(20, 1'b1, 1'b0);
        test_name = "ff_hold";
        push_button(600, 1'b1, 1'b0);
        test_name = "ff_disabled";
        bus_write(ADDR_FF_EN, 32'h0);
        push_button(50, 1'b0, 1'b0);

        test_name = "audio_mute";
        bus_write(ADDR_FF_EN, 32'h1);
        push_button(50, 1'b1, 1'b1);
        drive_video(100);
        test_name = "audio_sound";
        bus_write(ADDR_FF_SND_EN, 32'h1);
        drive_video(100);
        push_button(20, 1'b1, 1'b0);
        drive_video(10);

        // last falling-edge comparison is done by the next rising edge
        @(posedge clk_sys);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/gbc_av_top.sv ====
`timescale 1ns/100ps

module gbc_av_top (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  gbc_pkg::bridge_addr_t bridge_addr,
    input  logic                  bridge_wr,
    input  gbc_pkg::bridge_data_t bridge_wr_data,
    input  logic                  ff_button,
    input  gbc_pkg::rgb_t         src_rgb,
    input  logic                  src_hs,
    input  logic                  src_vs,
    input  logic                  src_hblank,
    input  logic                  src_vblank,
    input  gbc_pkg::sample_t      audio_l_in,
    input  gbc_pkg::sample_t      audio_r_in,
    output gbc_pkg::rgb_t         video_rgb,
    output logic                  video_de,
    output logic                  video_hs,
    output logic                  video_vs,
    output gbc_pkg::sample_t      audio_l,
    output gbc_pkg::sample_t      audio_r,
    output logic                  core_reset,
    output logic                  ff_active
);

    // settings shared by all blocks
    settings_if i_settings ();

    cfg_regs i_cfg_regs (
        .clk_sys        (clk_sys),
        .arst_n         (arst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .cfg            (i_settings.regs)
    );

    ff_fsm i_ff_fsm (
        .clk_sys   (clk_sys),
        .arst_n    (arst_n),
        .ff_button (ff_button),
        .cfg       (i_settings.user),
        .ff_active (ff_active)
    );

    av_output i_av_output (
        .clk_sys    (clk_sys),
        .arst_n     (arst_n),
        .src_rgb    (src_rgb),
        .src_hs     (src_hs),
        .src_vs     (src_vs),
        .src_hblank (src_hblank),
        .src_vblank (src_vblank),
        .audio_l_in (audio_l_in),
        .audio_r_in (audio_r_in),
        .ff_active  (ff_active),
        .cfg        (i_settings.user),
        .video_rgb  (video_rgb),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .audio_l    (audio_l),
        .audio_r    (audio_r)
    );

    assign core_reset = i_settings.core_reset;

endmodule

// ==== logic/av_output.sv ====
`timescale 1ns/100ps

module av_output (
    input  logic             clk_sys,
    input  logic             arst_n,
    input  gbc_pkg::rgb_t    src_rgb,
    input  logic             src_hs,
    input  logic             src_vs,
    input  logic             src_hblank,
    input  logic             src_vblank,
    input  gbc_pkg::sample_t audio_l_in,
    input  gbc_pkg::sample_t audio_r_in,
    input  logic             ff_active,
    settings_if.user         cfg,
    output gbc_pkg::rgb_t    video_rgb,
    output logic             video_de,
    output logic             video_hs,
    output logic             video_vs,
    output gbc_pkg::sample_t audio_l,
    output gbc_pkg::sample_t audio_r
);

    import gbc_pkg::*;

    typedef logic [$clog2(HS_DELAY_CYCLES + 1) - 1:0] hs_cnt_t;

    logic    de;
    logic    hs_prev;
    logic    vs_prev;
    hs_cnt_t hs_cnt;
    rgb_t    rgb_q;
    logic    mute;

    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [7:0] lum;

    ////////////////////////////////////////
    // sync and data enable
    ////////////////////////////////////////

    assign de = ~(src_hblank | src_vblank);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            video_de <= 1'b0;
            video_vs <= 1'b0;
            video_hs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_cnt   <= '0;
        end else begin
            video_de <= de;
            // single-cycle vsync on the source rising edge
            video_vs <= src_vs & ~vs_prev;
            video_hs <= (hs_cnt == hs_cnt_t'(1));
            hs_prev  <= src_hs;
            vs_prev  <= src_vs;
            // hsync rise reloads the delay
            if (src_hs && !hs_prev) begin
                hs_cnt <= hs_cnt_t'(HS_DELAY_CYCLES);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - hs_cnt_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // pixel and audio payload
    ////////////////////////////////////////

    assign mute = ff_active & ~cfg.ff_snd_en;

    always_ff @(posedge clk_sys) begin
        // black outside active video
        rgb_q   <= de ? src_rgb : '0;
        audio_l <= mute ? '0 : audio_l_in;
        audio_r <= mute ? '0 : audio_r_in;
    end

    // approximate luma from shifts, wraps at 8 bits
    assign red   = rgb_q[23:16];
    assign green = rgb_q[15:8];
    assign blue  = rgb_q[7:0];
    assign lum   = (red >> 2) + (red >> 5) + (green >> 1) + (green >> 4)
                 + (blue >> 4) + (blue >> 5);

    assign video_rgb = cfg.bw_en ? {lum, lum, lum} : rgb_q;

endmodule

// ==== logic/ff_fsm.sv ====
`timescale 1ns/100ps

module ff_fsm (
    input  logic     clk_sys,
    input  logic     arst_n,
    input  logic     ff_button,
    settings_if.user cfg,
    output logic     ff_active
);

    import gbc_pkg::*;

    ff_state_t state;
    ff_state_t state_next;

    logic req;
    logic req_prev;
    logic req_rise;
    logic req_fall;
    logic tap_start;
    logic tap_running;

    // button only counts while fast-forward is enabled
    assign req      = ff_button & cfg.ff_en;
    assign req_rise = req & ~req_prev;
    assign req_fall = ~req & req_prev;

    // tap window opens on the first press only
    assign tap_start = (state == FF_OFF) && req_rise;

    cycle_timer #(
        .LOAD_CYCLES (FF_TAP_CYCLES)
    ) i_tap_timer (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .start   (tap_start),
        .running (tap_running)
    );

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            FF_OFF: begin
                if (req_rise) begin
                    state_next = FF_PRESS;
                end
            end
            FF_PRESS: begin
                // release in the window latches, late release just stops
                if (req_fall) begin
                    state_next = tap_running ? FF_LATCHED : FF_OFF;
                end else if (!tap_running) begin
                    state_next = FF_HOLD;
                end
            end
            FF_HOLD: begin
                if (req_fall) begin
                    state_next = FF_OFF;
                end
            end
            FF_LATCHED: begin
                if (req_rise) begin
                    state_next = FF_UNLATCH;
                end
            end
            FF_UNLATCH: begin
                if (req_fall) begin
                    state_next = FF_OFF;
                end
            end
            default: begin
                state_next = FF_OFF;
            end
        endcase
        // disabling fast-forward drops any latch
        if (!cfg.ff_en) begin
            state_next = FF_OFF;
        end
    end

    // ff_active tracks the state from the same edge
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state     <= FF_OFF;
            req_prev  <= 1'b0;
            ff_active <= 1'b0;
        end else begin
            state     <= state_next;
            req_prev  <= req;
            ff_active <= (state_next != FF_OFF);
        end
    end

endmodule

// ==== logic/cfg_regs.sv ====
`timescale 1ns/100ps

module cfg_regs (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  gbc_pkg::bridge_addr_t bridge_addr,
    input  logic                  bridge_wr,
    input  gbc_pkg::bridge_data_t bridge_wr_data,
    settings_if.regs              cfg
);

    import gbc_pkg::*;

    logic ff_en_q;
    logic ff_snd_en_q;
    logic bw_en_q;
    logic reset_start;

    ////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////

    // only bit 0 of the write data matters
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            ff_en_q     <= 1'b0;
            ff_snd_en_q <= 1'b0;
            bw_en_q     <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_FF_EN: begin
                    ff_en_q <= bridge_wr_data[0];
                end
                ADDR_FF_SND_EN: begin
                    ff_snd_en_q <= bridge_wr_data[0];
                end
                ADDR_BW_EN: begin
                    bw_en_q <= bridge_wr_data[0];
                end
                default: begin
                    // unmapped address, write dropped
                end
            endcase
        end
    end

    assign cfg.ff_en     = ff_en_q;
    assign cfg.ff_snd_en = ff_snd_en_q;
    assign cfg.bw_en     = bw_en_q;

    ////////////////////////////////////////
    // core reset window
    ////////////////////////////////////////

    // the strobe itself counts as the first cycle
    assign reset_start = bridge_wr && (bridge_addr == ADDR_RESET);

    cycle_timer #(
        .LOAD_CYCLES (RESET_HOLD_CYCLES)
    ) i_reset_timer (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .start   (reset_start),
        .running (cfg.core_reset)
    );

endmodule

// ==== logic/cycle_timer.sv ====
`timescale 1ns/100ps

module cycle_timer #(
    parameter int LOAD_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic arst_n,
    input  logic start,
    output logic running
);

    // just wide enough for the load value
    typedef logic [$clog2(LOAD_CYCLES + 1) - 1:0] count_t;

    count_t count;

    // a new start reloads, even mid-window
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (start) begin
            count <= count_t'(LOAD_CYCLES);
        end else if (count != '0) begin
            count <= count - count_t'(1);
        end
    end

    // high from the start edge for LOAD_CYCLES cycles
    assign running = (count != '0);

endmodule

// ==== logic/settings_if.sv ====
`timescale 1ns/100ps

// decoded host settings, one writer and several readers
interface settings_if;

    logic ff_en;
    logic ff_snd_en;
    logic bw_en;
    logic core_reset;

    modport regs (
        output ff_en,
        output ff_snd_en,
        output bw_en,
        output core_reset
    );

    modport user (
        input ff_en,
        input ff_snd_en,
        input bw_en,
        input core_reset
    );

endinterface

// ==== logic/gbc_pkg.sv ====
package gbc_pkg;

    ////////////////////////////////////////
    // bus and data widths
    ////////////////////////////////////////

    // host bridge
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // pixel as {red, green, blue}
    typedef logic [23:0] rgb_t;

    // signed pcm sample
    typedef logic signed [15:0] sample_t;

    ////////////////////////////////////////
    // bridge register map
    ////////////////////////////////////////

    localparam bridge_addr_t ADDR_RESET     = 32'h0000_0050;
    localparam bridge_addr_t ADDR_FF_EN     = 32'h0000_020C;
    localparam bridge_addr_t ADDR_FF_SND_EN = 32'h0000_0210;
    localparam bridge_addr_t ADDR_BW_EN     = 32'h0000_0218;

    ////////////////////////////////////////
    // timing constants
    ////////////////////////////////////////

    // core reset length in clk_sys cycles
    localparam int RESET_HOLD_CYCLES = 256;
    // a release inside this window counts as a tap
    localparam int FF_TAP_CYCLES     = 400;
    // keeps hsync clear of the vsync pulse
    localparam int HS_DELAY_CYCLES   = 7;

    // fast-forward button states
    typedef enum logic [2:0] {
        FF_OFF     = 3'd0,
        FF_PRESS   = 3'd1,
        FF_HOLD    = 3'd2,
        FF_LATCHED = 3'd3,
        FF_UNLATCH = 3'd4
    } ff_state_t;

endpackage
